// ==== design/ethpipe_mid.sv ====
module ethpipe_mid import ethpipe_pkg::*; (
  input  logic        clk_125,
  input  logic        sys_rst,
  input  logic        gmii_rx_dv_i,
  input  logic [7:0]  gmii_rxd_i,
  input  logic        host_req_i,
  input  host_req_t   host_cmd_i,
  output logic        host_ack_o,
  output logic [15:0] host_rdata_o
);

  host_req_t    fwd_req;
  logic         reg_acc;
  logic         ram_acc0;
  logic         ram_acc1;
  logic [15:0]  reg_q;
  logic [15:0]  ram_q0;
  logic [15:0]  ram_q1;
  logic [63:0]  timer;
  logic         timer_clr;
  slot_status_t status;
  ram_wr_t      wr0;
  ram_wr_t      wr1;
  logic         frame_done;
  logic         done_slot;
  logic         drop;

  // ----------------------------------------------------------------------
  // Host side
  // ----------------------------------------------------------------------
  host_bus_port u_port (
    .clk_125    (clk_125),
    .sys_rst    (sys_rst),
    .req_i      (host_req_i),
    .host_req_i (host_cmd_i),
    .ack_o      (host_ack_o),
    .rdata_o    (host_rdata_o),
    .reg_acc_o  (reg_acc),
    .ram_acc0_o (ram_acc0),
    .ram_acc1_o (ram_acc1),
    .reg_q_i    (reg_q),
    .ram_q0_i   (ram_q0),
    .ram_q1_i   (ram_q1),
    .fwd_req_o  (fwd_req)
  );

  host_regs u_regs (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .acc_i        (reg_acc),
    .req_i        (fwd_req),
    .rdata_o      (reg_q),
    .timer_i      (timer),
    .timer_clr_o  (timer_clr),
    .frame_done_i (frame_done),
    .slot_i       (done_slot),
    .drop_i       (drop),
    .status_o     (status)
  );

  global_timer u_timer (
    .clk_125 (clk_125),
    .sys_rst (sys_rst),
    .clr_i   (timer_clr),
    .count_o (timer)
  );

  // ----------------------------------------------------------------------
  // Receive side
  // ----------------------------------------------------------------------
  gmii_rx_fsm u_rx (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .rx_dv_i      (gmii_rx_dv_i),
    .rx_data_i    (gmii_rxd_i),
    .status_i     (status),
    .wr0_o        (wr0),
    .wr1_o        (wr1),
    .frame_done_o (frame_done),
    .slot_o       (done_slot),
    .drop_o       (drop)
  );

  slot_ram u_slot0 (
    .clk_125    (clk_125),
    .host_en_i  (ram_acc0),
    .host_req_i (fwd_req),
    .host_q_o   (ram_q0),
    .wr_i       (wr0)
  );

  slot_ram u_slot1 (
    .clk_125    (clk_125),
    .host_en_i  (ram_acc1),
    .host_req_i (fwd_req),
    .host_q_o   (ram_q1),
    .wr_i       (wr1)
  );

endmodule

// ==== design/ethpipe_pkg.sv ====
package ethpipe_pkg;

  // ----------------------------------------------------------------------
  // Slot geometry
  // ----------------------------------------------------------------------
  localparam int SLOT_WORDS      = 1024;
  localparam int SLOT_AW         = 10;
  // Longer frames are cut here
  localparam int MAX_FRAME_BYTES = 2044;

  // ----------------------------------------------------------------------
  // Register map, word addresses
  // ----------------------------------------------------------------------
  localparam logic [14:0] REG_ADDR_STATUS       = 15'h00;
  localparam logic [14:0] REG_ADDR_TIME0        = 15'h02;
  localparam logic [14:0] REG_ADDR_TIME1        = 15'h03;
  localparam logic [14:0] REG_ADDR_TIME2        = 15'h04;
  localparam logic [14:0] REG_ADDR_TIME3        = 15'h05;
  localparam logic [14:0] REG_ADDR_DROPS        = 15'h06;
  localparam logic [14:0] REG_ADDR_DMA_STATUS   = 15'h08;
  localparam logic [14:0] REG_ADDR_DMA_CUR_LO   = 15'h0A;
  localparam logic [14:0] REG_ADDR_DMA_CUR_HI   = 15'h0B;
  localparam logic [14:0] REG_ADDR_DMA_START_LO = 15'h0C;
  localparam logic [14:0] REG_ADDR_DMA_START_HI = 15'h0D;
  localparam logic [14:0] REG_ADDR_DMA_END_LO   = 15'h0E;
  localparam logic [14:0] REG_ADDR_DMA_END_HI   = 15'h0F;

  localparam logic [31:0] DMA_START_RST = 32'hD000_0000;
  localparam logic [31:0] DMA_END_RST   = 32'hD001_0000;

  // Address bits of the host word address
  localparam int ADR_RAM_BIT  = 15;
  localparam int ADR_SLOT_BIT = 14;

  // Bit positions in the status register
  localparam int STAT_FULL0_BIT = 0;
  localparam int STAT_FULL1_BIT = 1;

  typedef struct packed {
    logic        we;
    logic [15:1] adr;
    logic [15:0] dat;
    logic [1:0]  sel;
  } host_req_t;

  typedef struct packed {
    logic               en;
    logic [SLOT_AW-1:0] addr;
    logic [15:0]        data;
    logic [1:0]         be;
  } ram_wr_t;

  typedef struct packed {
    logic full1;
    logic full0;
  } slot_status_t;

endpackage

// ==== design/global_timer.sv ====
module global_timer (
  input  logic        clk_125,
  input  logic        sys_rst,
  input  logic        clr_i,
  output logic [63:0] count_o
);

  logic [63:0] count_q;

  // Free running, cleared by reset or host request
  always_ff @(posedge clk_125) begin
    if (sys_rst || clr_i) begin
      count_q <= 64'd0;
    end else begin
      count_q <= count_q + 64'd1;
    end
  end

  assign count_o = count_q;

endmodule

// ==== design/gmii_rx_fsm.sv ====
module gmii_rx_fsm import ethpipe_pkg::*; (
  input  logic         clk_125,
  input  logic         sys_rst,
  input  logic         rx_dv_i,
  input  logic [7:0]   rx_data_i,
  input  slot_status_t status_i,
  output ram_wr_t      wr0_o,
  output ram_wr_t      wr1_o,
  output logic         frame_done_o,
  output logic         slot_o,
  output logic         drop_o
);

  typedef enum logic [1:0] {IDLE, DATA, LEN, DISCARD} state_t;

  state_t             state_q;
  logic               pref_q;
  logic               slot_q;
  logic [11:0]        cnt_q;
  logic [7:0]         lo_q;
  ram_wr_t            wr_q;
  logic               done_q;
  logic               drop_q;
  logic [1:0]         busy;
  logic [SLOT_AW-1:0] word_addr;

  // A slot completed last cycle is not yet in status
  always_comb begin
    busy = {status_i.full1, status_i.full0};
    if (done_q) busy[slot_q] = 1'b1;
  end

  // Frame bytes start at word 1
  assign word_addr = SLOT_AW'(cnt_q[11:1]) + SLOT_AW'(1);

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state_q <= IDLE;
      pref_q  <= 1'b0;
      slot_q  <= 1'b0;
      cnt_q   <= 12'd0;
      wr_q.en <= 1'b0;
      done_q  <= 1'b0;
      drop_q  <= 1'b0;
    end else begin
      wr_q.en <= 1'b0;
      done_q  <= 1'b0;
      drop_q  <= 1'b0;
      case (state_q)
        IDLE: begin
          if (rx_dv_i) begin
            cnt_q <= 12'd1;
            lo_q  <= rx_data_i;
            if (!busy[pref_q]) begin
              slot_q  <= pref_q;
              state_q <= DATA;
            end else if (!busy[~pref_q]) begin
              slot_q  <= ~pref_q;
              state_q <= DATA;
            end else begin
              drop_q  <= 1'b1;
              state_q <= DISCARD;
            end
          end
        end
        DATA: begin
          if (rx_dv_i) begin
            if (cnt_q < 12'(MAX_FRAME_BYTES)) begin
              cnt_q <= cnt_q + 12'd1;
              if (cnt_q[0]) begin
                wr_q.en   <= 1'b1;
                wr_q.addr <= word_addr;
                wr_q.data <= {rx_data_i, lo_q};
                wr_q.be   <= 2'b11;
              end else begin
                lo_q <= rx_data_i;
              end
            end
          end else begin
            // Length word, preferred slot flips for the next frame
            wr_q.en   <= 1'b1;
            wr_q.addr <= '0;
            wr_q.data <= {4'h0, cnt_q};
            wr_q.be   <= 2'b11;
            pref_q    <= ~pref_q;
            state_q   <= LEN;
          end
        end
        LEN: begin
          done_q  <= 1'b1;
          state_q <= IDLE;
          // Odd tail byte, low lane only
          if (cnt_q[0]) begin
            wr_q.en   <= 1'b1;
            wr_q.addr <= word_addr;
            wr_q.data <= {8'h00, lo_q};
            wr_q.be   <= 2'b01;
          end
        end
        default: begin
          if (!rx_dv_i) state_q <= IDLE;
        end
      endcase
    end
  end

  always_comb begin
    wr0_o    = wr_q;
    wr1_o    = wr_q;
    wr0_o.en = wr_q.en & ~slot_q;
    wr1_o.en = wr_q.en & slot_q;
  end

  assign frame_done_o = done_q;
  assign slot_o       = slot_q;
  assign drop_o       = drop_q;

  // Slot ownership is handed back only through the host status register
  a_no_write_full0: assert property (@(posedge clk_125) disable iff (sys_rst)
    wr0_o.en |-> !status_i.full0);
  a_no_write_full1: assert property (@(posedge clk_125) disable iff (sys_rst)
    wr1_o.en |-> !status_i.full1);

endmodule

// ==== design/host_bus_port.sv ====
module host_bus_port import ethpipe_pkg::*; (
  input  logic        clk_125,
  input  logic        sys_rst,
  input  logic        req_i,
  input  host_req_t   host_req_i,
  output logic        ack_o,
  output logic [15:0] rdata_o,
  output logic        reg_acc_o,
  output logic        ram_acc0_o,
  output logic        ram_acc1_o,
  input  logic [15:0] reg_q_i,
  input  logic [15:0] ram_q0_i,
  input  logic [15:0] ram_q1_i,
  output host_req_t   fwd_req_o
);

  typedef enum logic [1:0] {IDLE, ACCESS, WAIT_RELEASE} state_t;

  state_t    state_q;
  host_req_t cmd_q;
  logic      is_ram;
  logic      is_slot1;

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (req_i) state_q <= ACCESS;
        ACCESS:  state_q <= WAIT_RELEASE;
        default: if (!req_i) state_q <= IDLE;
      endcase
    end
  end

  // Request held for the whole transfer
  always_ff @(posedge clk_125) begin
    if (state_q == IDLE && req_i) cmd_q <= host_req_i;
  end

  assign is_ram   = cmd_q.adr[ADR_RAM_BIT];
  assign is_slot1 = cmd_q.adr[ADR_SLOT_BIT];

  // One strobe per transfer
  assign reg_acc_o  = (state_q == ACCESS) & ~is_ram;
  assign ram_acc0_o = (state_q == ACCESS) & is_ram & ~is_slot1;
  assign ram_acc1_o = (state_q == ACCESS) & is_ram & is_slot1;
  assign fwd_req_o  = cmd_q;

  // Targets hold their read data until the next strobe
  assign rdata_o = is_ram ? (is_slot1 ? ram_q1_i : ram_q0_i) : reg_q_i;
  assign ack_o   = (state_q == WAIT_RELEASE);

  a_ack_release: assert property (@(posedge clk_125) disable iff (sys_rst)
    $fell(ack_o) |-> $past(!req_i));

endmodule

// ==== design/host_regs.sv ====
module host_regs import ethpipe_pkg::*; (
  input  logic         clk_125,
  input  logic         sys_rst,
  input  logic         acc_i,
  input  host_req_t    req_i,
  output logic [15:0]  rdata_o,
  input  logic [63:0]  timer_i,
  output logic         timer_clr_o,
  input  logic         frame_done_i,
  input  logic         slot_i,
  input  logic         drop_i,
  output slot_status_t status_o
);

  slot_status_t status_q;
  logic [63:0]  snap_q;
  logic [15:0]  drops_q;
  logic [7:0]   dma_status_q;
  logic [31:0]  dma_cur_q;
  logic [31:0]  dma_start_q;
  logic [31:0]  dma_end_q;
  logic         clr_q;
  logic         wr_en;
  logic         rd_en;
  logic [15:0]  rd_mux;

  assign wr_en = acc_i & req_i.we;
  assign rd_en = acc_i & ~req_i.we;

  // Byte lane merge for the DMA address halves
  function automatic logic [15:0] be_merge(input logic [15:0] old_v,
                                           input logic [15:0] new_v,
                                           input logic [1:0]  sel);
    logic [15:0] res;
    res = old_v;
    if (sel[0]) res[7:0] = new_v[7:0];
    if (sel[1]) res[15:8] = new_v[15:8];
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      status_q     <= '0;
      drops_q      <= 16'd0;
      clr_q        <= 1'b0;
      dma_status_q <= 8'h00;
      dma_cur_q    <= DMA_START_RST;
      dma_start_q  <= DMA_START_RST;
      dma_end_q    <= DMA_END_RST;
    end else begin
      clr_q <= wr_en && (req_i.adr == REG_ADDR_TIME0);
      if (drop_i && drops_q != 16'hFFFF) drops_q <= drops_q + 16'd1;

      // Write 1 to clear, a new frame takes priority
      if (wr_en && req_i.adr == REG_ADDR_STATUS && req_i.sel[0]) begin
        if (req_i.dat[STAT_FULL0_BIT]) status_q.full0 <= 1'b0;
        if (req_i.dat[STAT_FULL1_BIT]) status_q.full1 <= 1'b0;
      end
      if (frame_done_i) begin
        if (slot_i) status_q.full1 <= 1'b1;
        else        status_q.full0 <= 1'b1;
      end

      if (wr_en) begin
        case (req_i.adr)
          REG_ADDR_DMA_STATUS: begin
            if (req_i.sel[0]) dma_status_q <= req_i.dat[7:0];
          end
          REG_ADDR_DMA_CUR_LO:
            dma_cur_q[15:0] <= be_merge(dma_cur_q[15:0], req_i.dat, req_i.sel);
          REG_ADDR_DMA_CUR_HI:
            dma_cur_q[31:16] <= be_merge(dma_cur_q[31:16], req_i.dat, req_i.sel);
          REG_ADDR_DMA_START_LO:
            dma_start_q[15:0] <= be_merge(dma_start_q[15:0], req_i.dat, req_i.sel);
          REG_ADDR_DMA_START_HI:
            dma_start_q[31:16] <= be_merge(dma_start_q[31:16], req_i.dat, req_i.sel);
          REG_ADDR_DMA_END_LO:
            dma_end_q[15:0] <= be_merge(dma_end_q[15:0], req_i.dat, req_i.sel);
          REG_ADDR_DMA_END_HI:
            dma_end_q[31:16] <= be_merge(dma_end_q[31:16], req_i.dat, req_i.sel);
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read path
  // ----------------------------------------------------------------------
  always_comb begin
    rd_mux = 16'h0000;
    case (req_i.adr)
      REG_ADDR_STATUS: begin
        rd_mux[STAT_FULL0_BIT] = status_q.full0;
        rd_mux[STAT_FULL1_BIT] = status_q.full1;
      end
      REG_ADDR_TIME0:        rd_mux = timer_i[15:0];
      REG_ADDR_TIME1:        rd_mux = snap_q[31:16];
      REG_ADDR_TIME2:        rd_mux = snap_q[47:32];
      REG_ADDR_TIME3:        rd_mux = snap_q[63:48];
      REG_ADDR_DROPS:        rd_mux = drops_q;
      REG_ADDR_DMA_STATUS:   rd_mux = {8'h00, dma_status_q};
      REG_ADDR_DMA_CUR_LO:   rd_mux = dma_cur_q[15:0];
      REG_ADDR_DMA_CUR_HI:   rd_mux = dma_cur_q[31:16];
      REG_ADDR_DMA_START_LO: rd_mux = dma_start_q[15:0];
      REG_ADDR_DMA_START_HI: rd_mux = dma_start_q[31:16];
      REG_ADDR_DMA_END_LO:   rd_mux = dma_end_q[15:0];
      REG_ADDR_DMA_END_HI:   rd_mux = dma_end_q[31:16];
      default:               rd_mux = 16'h0000;
    endcase
  end

  // Whole counter is frozen when the low word is read
  always_ff @(posedge clk_125) begin
    if (rd_en && req_i.adr == REG_ADDR_TIME0) snap_q <= timer_i;
    if (acc_i) rdata_o <= rd_mux;
  end

  assign timer_clr_o = clr_q;
  assign status_o    = status_q;

  // The writer only completes frames into slots it was given as free
  a_done_into_free: assert property (@(posedge clk_125) disable iff (sys_rst)
    frame_done_i |-> !(slot_i ? status_q.full1 : status_q.full0));

endmodule

// ==== design/slot_ram.sv ====
module slot_ram import ethpipe_pkg::*; (
  input  logic        clk_125,
  input  logic        host_en_i,
  input  host_req_t   host_req_i,
  output logic [15:0] host_q_o,
  input  ram_wr_t     wr_i
);

  logic [15:0] mem [SLOT_WORDS];
  logic [SLOT_AW-1:0] host_addr;

  assign host_addr = host_req_i.adr[SLOT_AW:1];

  // Writer port is applied last so it wins a same-word collision
  always_ff @(posedge clk_125) begin
    if (host_en_i && host_req_i.we) begin
      if (host_req_i.sel[0]) mem[host_addr][7:0] <= host_req_i.dat[7:0];
      if (host_req_i.sel[1]) mem[host_addr][15:8] <= host_req_i.dat[15:8];
    end
    if (wr_i.en) begin
      if (wr_i.be[0]) mem[wr_i.addr][7:0] <= wr_i.data[7:0];
      if (wr_i.be[1]) mem[wr_i.addr][15:8] <= wr_i.data[15:8];
    end
  end

  // Host read, one cycle latency
  always_ff @(posedge clk_125) begin
    if (host_en_i) begin
      host_q_o <= mem[host_addr];
    end
  end

endmodule

// ==== filelist.f ====
design/ethpipe_pkg.sv
design/slot_ram.sv
design/global_timer.sv
design/gmii_rx_fsm.sv
design/host_regs.sv
design/host_bus_port.sv
design/ethpipe_mid.sv
tb/ethpipe_mid_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

if ! verilator --binary --assert --timescale 1ns/1ps \
    --top-module ethpipe_mid_tb -f filelist.f -Mdir obj_dir -o sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation returned status $status"
  exit "$status"
fi

exit 0

// ==== tb/ethpipe_mid_tb.sv ====
module ethpipe_mid_tb import ethpipe_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PREFILL_WORDS = 36;
  localparam int N_STEPS       = 52;

  localparam logic [1:0] K_READ  = 2'd0;
  localparam logic [1:0] K_WRITE = 2'd1;
  localparam logic [1:0] K_FRAME = 2'd2;

  // One table row: a host access or a frame of dat bytes
  typedef struct packed {
    logic [1:0]  kind;
    logic [15:1] adr;
    logic [15:0] dat;
    logic [1:0]  sel;
    logic [15:0] exp_val;
  } step_t;

  localparam step_t STEPS [N_STEPS] = '{
    // Reset values
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DROPS,        16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DMA_START_LO, 16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DMA_START_HI, 16'h0000, 2'b11, 16'hD000},
    '{K_READ,  REG_ADDR_DMA_CUR_LO,   16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DMA_CUR_HI,   16'h0000, 2'b11, 16'hD000},
    '{K_READ,  REG_ADDR_DMA_END_LO,   16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DMA_END_HI,   16'h0000, 2'b11, 16'hD001},
    // Single frames, each slot cleared afterwards
    '{K_FRAME, 15'h0000,              16'd64,   2'b00, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0001},
    '{K_WRITE, REG_ADDR_STATUS,       16'h0001, 2'b01, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0000},
    '{K_FRAME, 15'h0000,              16'd61,   2'b00, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0002},
    '{K_WRITE, REG_ADDR_STATUS,       16'h0002, 2'b01, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0000},
    '{K_FRAME, 15'h0000,              16'd1,    2'b00, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0001},
    '{K_WRITE, REG_ADDR_STATUS,       16'h0001, 2'b01, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0000},
    // Brings the preferred slot back to 0
    '{K_FRAME, 15'h0000,              16'd20,   2'b00, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0002},
    '{K_WRITE, REG_ADDR_STATUS,       16'h0002, 2'b01, 16'h0000},
    // Both slots fill, third frame dropped
    '{K_FRAME, 15'h0000,              16'd30,   2'b00, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0001},
    '{K_FRAME, 15'h0000,              16'd33,   2'b00, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0003},
    '{K_FRAME, 15'h0000,              16'd16,   2'b00, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0003},
    '{K_READ,  REG_ADDR_DROPS,        16'h0000, 2'b11, 16'h0001},
    '{K_WRITE, REG_ADDR_STATUS,       16'h0003, 2'b01, 16'h0000},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0000},
    // DMA byte lanes
    '{K_WRITE, REG_ADDR_DMA_START_LO, 16'h1234, 2'b01, 16'h0000},
    '{K_WRITE, REG_ADDR_DMA_END_HI,   16'hAB55, 2'b10, 16'h0000},
    '{K_WRITE, REG_ADDR_DMA_CUR_HI,   16'h1357, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DMA_START_LO, 16'h0000, 2'b11, 16'h0034},
    '{K_READ,  REG_ADDR_DMA_START_HI, 16'h0000, 2'b11, 16'hD000},
    '{K_READ,  REG_ADDR_DMA_END_HI,   16'h0000, 2'b11, 16'hAB01},
    '{K_READ,  REG_ADDR_DMA_END_LO,   16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DMA_CUR_HI,   16'h0000, 2'b11, 16'h1357},
    '{K_READ,  REG_ADDR_DMA_CUR_LO,   16'h0000, 2'b11, 16'h0000},
    // Holes in the map
    '{K_WRITE, 15'h0001,              16'hFFFF, 2'b11, 16'h0000},
    '{K_WRITE, 15'h0009,              16'hFFFF, 2'b11, 16'h0000},
    '{K_WRITE, 15'h0010,              16'hFFFF, 2'b11, 16'h0000},
    '{K_READ,  15'h0001,              16'h0000, 2'b11, 16'h0000},
    '{K_READ,  15'h0009,              16'h0000, 2'b11, 16'h0000},
    '{K_READ,  15'h0010,              16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DMA_START_LO, 16'h0000, 2'b11, 16'h0034},
    '{K_READ,  REG_ADDR_DMA_END_HI,   16'h0000, 2'b11, 16'hAB01},
    '{K_READ,  REG_ADDR_DMA_CUR_HI,   16'h0000, 2'b11, 16'h1357},
    '{K_READ,  REG_ADDR_STATUS,       16'h0000, 2'b11, 16'h0000},
    '{K_READ,  REG_ADDR_DROPS,        16'h0000, 2'b11, 16'h0001}
  };

  logic        clk_125;
  logic        sys_rst;
  logic        gmii_rx_dv;
  logic [7:0]  gmii_rxd;
  logic        host_req;
  host_req_t   host_cmd;
  logic        host_ack;
  logic [15:0] host_rdata;

  // Reference model of slot contents and writer state
  logic [15:0] mslot [2][PREFILL_WORDS];
  logic [1:0]  mstat;
  logic        mpref;
  logic [15:0] mdrops;

  int cycles;
  int limit;

  ethpipe_mid dut (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .gmii_rx_dv_i (gmii_rx_dv),
    .gmii_rxd_i   (gmii_rxd),
    .host_req_i   (host_req),
    .host_cmd_i   (host_cmd),
    .host_ack_o   (host_ack),
    .host_rdata_o (host_rdata)
  );

  initial begin
    clk_125 = 1'b0;
    forever #5 clk_125 = ~clk_125;
  end

  // ----------------------------------------------------------------------
  // Checking and run limit
  // ----------------------------------------------------------------------
  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp_v);
    if (got !== exp_v) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp_v);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int compute_limit();
    int frame_cyc;
    int acc;
    frame_cyc = 0;
    acc = 2 * PREFILL_WORDS;
    for (int i = 0; i < N_STEPS; i++) begin
      if (STEPS[i].kind == K_FRAME) begin
        frame_cyc += int'(STEPS[i].dat) + 14;
        acc += 2 * PREFILL_WORDS;
      end else begin
        acc += 1;
      end
    end
    // Timer and handshake section, hold time included
    acc += 20;
    return 4 * (frame_cyc + 4 * acc) + 1000;
  endfunction

  initial begin
    limit = compute_limit();
    cycles = 0;
    forever begin
      @(posedge clk_125);
      cycles++;
      if (cycles > limit) begin
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $fatal(1, "timeout");
      end
    end
  end

  // ----------------------------------------------------------------------
  // Host bus and GMII drivers
  // ----------------------------------------------------------------------
  task automatic host_access(input logic we, input logic [15:1] adr, input logic [15:0] dat,
                             input logic [1:0] sel, input int hold, output logic [15:0] rdata);
    int rise;
    int fall;
    host_cmd = '{we: we, adr: adr, dat: dat, sel: sel};
    host_req = 1'b1;
    rise = 0;
    do begin
      @(posedge clk_125);
      #1;
      rise++;
    end while (!host_ack);
    rdata = host_rdata;
    // A slow host keeps req up, ack and data must stay
    repeat (hold) begin
      @(posedge clk_125);
      #1;
      check("host_ack_o while held", 16'(host_ack), 16'd1);
      check("host_rdata_o while held", host_rdata, rdata);
    end
    host_req = 1'b0;
    fall = 0;
    do begin
      @(posedge clk_125);
      #1;
      fall++;
    end while (host_ack);
    check("host_ack_o rise edges", 16'(rise), 16'd2);
    check("host_ack_o fall edges", 16'(fall), 16'd1);
  endtask

  task automatic do_write(input logic [15:1] adr, input logic [15:0] dat, input logic [1:0] sel);
    logic [15:0] ignored;
    host_access(1'b1, adr, dat, sel, 0, ignored);
  endtask

  task automatic do_read(input logic [15:1] adr, output logic [15:0] data);
    host_access(1'b0, adr, 16'h0000, 2'b11, 0, data);
  endtask

  function automatic logic [15:1] slot_adr(input int s, input int w);
    logic [15:1] a;
    a = '0;
    a[ADR_RAM_BIT] = 1'b1;
    a[ADR_SLOT_BIT] = s[0];
    a[SLOT_AW:1] = SLOT_AW'(w);
    return a;
  endfunction

  task automatic send_frame(input int len);
    logic [7:0] bytes [$];
    logic       s;
    logic       take;
    int         w;
    for (int i = 0; i < len; i++) bytes.push_back(8'($urandom));
    // Slot choice as the writer should make it
    take = 1'b1;
    s = mpref;
    if (!mstat[mpref]) s = mpref;
    else if (!mstat[~mpref]) s = ~mpref;
    else take = 1'b0;
    if (take) begin
      mslot[s][0] = 16'(len);
      for (int i = 0; i < len; i++) begin
        w = 1 + i / 2;
        if (i % 2 == 0) mslot[s][w][7:0] = bytes[i];
        else mslot[s][w][15:8] = bytes[i];
      end
      mstat[s] = 1'b1;
      mpref = ~mpref;
    end else begin
      mdrops = mdrops + 16'd1;
    end
    for (int i = 0; i < len; i++) begin
      gmii_rx_dv = 1'b1;
      gmii_rxd = bytes[i];
      @(posedge clk_125);
      #1;
    end
    gmii_rx_dv = 1'b0;
    gmii_rxd = 8'h00;
    // Interframe gap
    repeat (12) begin
      @(posedge clk_125);
      #1;
    end
  endtask

  task automatic check_slots();
    logic [15:0] rd;
    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < PREFILL_WORDS; w++) begin
        do_read(slot_adr(s, w), rd);
        check($sformatf("slot%0d word %0d", s, w), rd, mslot[s][w]);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    step_t       st;
    logic [15:0] rd;
    logic [15:0] t0;
    logic [15:0] t1;
    logic [15:1] a;
    sys_rst = 1'b1;
    gmii_rx_dv = 1'b0;
    gmii_rxd = 8'h00;
    host_req = 1'b0;
    host_cmd = '0;
    mstat = 2'b00;
    mpref = 1'b0;
    mdrops = 16'd0;
    void'($urandom(67));
    repeat (8) @(posedge clk_125);
    #1;
    sys_rst = 1'b0;

    // Known contents so untouched lanes are predictable
    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < PREFILL_WORDS; w++) begin
        a = slot_adr(s, w);
        mslot[s][w] = {a, 1'b0} ^ 16'hC3A5;
        do_write(a, mslot[s][w], 2'b11);
      end
    end

    for (int i = 0; i < N_STEPS; i++) begin
      st = STEPS[i];
      case (st.kind)
        K_FRAME: begin
          send_frame(int'(st.dat));
          check_slots();
        end
        K_WRITE: begin
          do_write(st.adr, st.dat, st.sel);
          if (st.adr == REG_ADDR_STATUS && st.sel[0]) mstat = mstat & ~st.dat[1:0];
        end
        default: begin
          do_read(st.adr, rd);
          check($sformatf("host_rdata_o @ 0x%h", st.adr), rd, st.exp_val);
        end
      endcase
    end

    // Timer cleared, then snapshot read high word first
    do_write(REG_ADDR_TIME0, 16'h0000, 2'b11);
    do_read(REG_ADDR_TIME0, t0);
    do_read(REG_ADDR_TIME3, rd);
    check("time3", rd, 16'h0000);
    do_read(REG_ADDR_TIME2, rd);
    check("time2", rd, 16'h0000);
    do_read(REG_ADDR_TIME1, rd);
    check("time1", rd, 16'h0000);
    check("time0 nonzero", 16'(t0 != 16'h0000), 16'd1);
    check("time0 below 64", 16'(t0 < 16'd64), 16'd1);
    repeat (20) begin
      @(posedge clk_125);
      #1;
    end
    do_read(REG_ADDR_TIME0, t1);
    check("time0 increased", 16'(t1 > t0), 16'd1);

    // Held request makes a single access
    // A repeated TIME0 read would move the returned data while held
    host_access(1'b0, REG_ADDR_TIME0, 16'h0000, 2'b11, 10, rd);
    check("time0 after held req", 16'(rd > t1), 16'd1);
    do_read(REG_ADDR_DROPS, rd);
    check("drops reread", rd, mdrops);

    $display("Testbench passed");
    $finish;
  end

endmodule
